// ==== common/huff_pkg.sv ====
/* shared types for the codebook generator; codes are at most 127 moves long
   null_child marks an empty slot and only shows up in a one-symbol tree */

package huff_pkg;

    localparam int sym_w  = 8;              // symbol width
    localparam int idx_w  = 7;              // node index width
    localparam int len_w  = 7;              // code length width
    localparam int path_w = 128;            // max code length + guard bit
    localparam int hdr_w  = sym_w + len_w;  // symbol + length field bits per entry

    // one slot of a tree node
    typedef struct packed {
        logic             is_sum;  // 1 = internal node, 0 = leaf symbol
        logic [sym_w-1:0] value;   // symbol, or node index in the low idx_w bits
    } child_t;

    // empty slot, sum flag with an index that can never be valid
    localparam child_t null_child = '{is_sum: 1'b1, value: 8'h80};

    typedef struct packed {
        child_t left;   // move 0
        child_t right;  // move 1
    } node_t;

    // one codebook entry, code right-aligned with the first move as its msb
    typedef struct packed {
        logic [sym_w-1:0]  sym;   // leaf symbol
        logic [len_w-1:0]  len;   // number of valid code bits
        logic [path_w-2:0] bits;  // code in bits[len-1:0]
    } code_entry_t;

    // walker FSM
    typedef enum logic [2:0] {
        init,       // idle after reset, waits for start
        left,       // fetch node, take left slot
        right,      // fetch node, take right slot
        send,       // entry handed off, wait for writer
        backtrack,  // pop moves until a left one is found
        track,      // re-fetch from the root along the saved path
        finish      // walk done, waits for the next start
    } cb_state_e;

endpackage

// ==== src/htree_mem.sv ====
/* node store for the tree, loaded through a plain write port
   reads are registered: rd_node/rd_valid follow rd_req by one cycle
   indices at or past node_count read back as two null children */

`timescale 1ns/10ps

module htree_mem #(
    parameter int node_count = 128
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      load_en,
    input  logic [huff_pkg::idx_w-1:0] load_index,
    input  huff_pkg::node_t           load_node,
    input  logic                      rd_req,
    input  logic [huff_pkg::idx_w-1:0] rd_index,
    output logic                      rd_valid,
    output huff_pkg::node_t           rd_node
);

    huff_pkg::node_t mem [node_count];  // node array, no reset

    always_ff @(posedge clk) begin
        if (load_en && (int'(load_index) < node_count)) begin
            mem[load_index] <= load_node;  // loading port
        end
        if (rd_req) begin
            if (int'(rd_index) < node_count) begin
                rd_node <= mem[rd_index];
            end else begin
                rd_node <= '{left: huff_pkg::null_child, right: huff_pkg::null_child};
            end
        end  // rd_node holds until the next read
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_req;  // one-cycle read latency
        end
    end

endmodule

// ==== codebook/cb_walker.sv ====
/* depth-first codebook walker, left before right, one code in flight at a time
   start is only honoured in init or finish; every node fetch is a 2-cycle read
   no parent pointers, so backtracking re-walks the saved path from the root */

`timescale 1ns/10ps

module cb_walker (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  logic [huff_pkg::idx_w-1:0] root_index,
    input  logic                       rd_valid,
    input  huff_pkg::node_t            rd_node,
    input  logic                       write_done,
    output logic                       rd_req,
    output logic [huff_pkg::idx_w-1:0] rd_index,
    output logic                       code_found,
    output huff_pkg::code_entry_t      code,
    output logic                       done
);

    localparam logic [huff_pkg::path_w-2:0] bit_one = 1;  // lsb set, shifted to the guard

    huff_pkg::cb_state_e          state, state_n;
    logic [huff_pkg::path_w-1:0]  path, path_n;            // moves, guard 1 above the oldest
    logic [huff_pkg::len_w-1:0]   track_len, track_len_n;  // moves currently on the path
    logic [huff_pkg::len_w-1:0]   pos, pos_n;              // re-track step
    logic [huff_pkg::idx_w-1:0]   cur_index, cur_index_n;  // node to fetch next
    logic [huff_pkg::idx_w-1:0]   root, root_n;            // root of the current tree
    logic                         pending;                 // read issued, data not back yet

    logic                         move;      // 0 left, 1 right
    huff_pkg::child_t             child;     // slot picked from rd_node
    logic [huff_pkg::path_w-1:0]  path_push;
    logic [huff_pkg::len_w-1:0]   len_push;
    logic [huff_pkg::len_w-1:0]   trk_bit;   // path bit of the re-track step

    assign rd_req   = !pending && ((state == huff_pkg::left) || (state == huff_pkg::right) ||
                                   (state == huff_pkg::track));
    assign rd_index = cur_index;
    assign done     = (state == huff_pkg::finish);  // cleared as start leaves finish

    // the move taken out of the fetched node
    assign trk_bit   = track_len - 7'd1 - pos;  // oldest saved move first
    assign move      = (state == huff_pkg::track) ? path[trk_bit] : (state == huff_pkg::right);
    assign child     = move ? rd_node.right : rd_node.left;
    assign path_push = {path[huff_pkg::path_w-2:0], move};
    assign len_push  = track_len + 7'd1;

    // entry for a leaf slot, guard bit xor'ed out of the pushed path
    assign code.sym  = child.value;
    assign code.len  = len_push;
    assign code.bits = path_push[huff_pkg::path_w-2:0] ^ (bit_one << len_push);

    always_comb begin
        state_n     = state;
        path_n      = path;
        track_len_n = track_len;
        pos_n       = pos;
        cur_index_n = cur_index;
        root_n      = root;
        code_found  = 1'b0;
        case (state)
            huff_pkg::init, huff_pkg::finish: begin
                if (start) begin
                    root_n      = root_index;
                    cur_index_n = root_index;
                    path_n      = 1;      // guard only, empty path
                    track_len_n = '0;
                    state_n     = huff_pkg::left;
                end
            end
            huff_pkg::left, huff_pkg::right: begin
                if (pending && rd_valid) begin
                    if (child == huff_pkg::null_child) begin
                        state_n = huff_pkg::finish;  // one-symbol tree, nothing to emit
                    end else begin
                        path_n      = path_push;
                        track_len_n = len_push;
                        if (child.is_sum) begin
                            cur_index_n = child.value[huff_pkg::idx_w-1:0];  // descend
                            state_n     = huff_pkg::left;
                        end else begin
                            code_found = 1'b1;  // leaf, hand entry to writer
                            state_n    = huff_pkg::send;
                        end
                    end
                end
            end
            huff_pkg::send: begin
                if (write_done) begin
                    state_n = huff_pkg::backtrack;
                end
            end
            huff_pkg::backtrack: begin
                if (track_len == '0) begin
                    state_n = huff_pkg::finish;  // both sides of the root are done
                end else begin
                    path_n      = path >> 1;  // pop one move per cycle
                    track_len_n = track_len - 7'd1;
                    if (!path[0]) begin
                        // left move popped, next try its right sibling
                        cur_index_n = root;
                        pos_n       = '0;
                        state_n     = (track_len == 7'd1) ? huff_pkg::right : huff_pkg::track;
                    end
                end
            end
            huff_pkg::track: begin
                if (pending && rd_valid) begin
                    cur_index_n = child.value[huff_pkg::idx_w-1:0];  // always a sum on the path
                    pos_n       = pos + 7'd1;
                    if (pos + 7'd1 == track_len) begin
                        state_n = huff_pkg::right;  // parent reached
                    end
                end
            end
            default: begin
                state_n = huff_pkg::init;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= huff_pkg::init;
            path      <= 1;
            track_len <= '0;
            pos       <= '0;
            cur_index <= '0;
            root      <= '0;
            pending   <= 1'b0;
        end else begin
            state     <= state_n;
            path      <= path_n;
            track_len <= track_len_n;
            pos       <= pos_n;
            cur_index <= cur_index_n;
            root      <= root_n;
            if (rd_req) begin
                pending <= 1'b1;
            end else if (rd_valid) begin
                pending <= 1'b0;
            end
        end
    end

endmodule

// ==== codebook/code_writer.sv ====
/* serializes one codebook entry: symbol, then length, then code, each msb first
   a new code_found while busy is not expected; the serial output has no stall */

`timescale 1ns/10ps

module code_writer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  code_found,
    input  huff_pkg::code_entry_t code,
    output logic                  bit_valid,
    output logic                  bit_data,
    output logic                  sym_start,
    output logic                  write_done
);

    huff_pkg::code_entry_t entry;     // latched entry, payload only
    logic                  busy;      // serializing
    logic [7:0]            slot;      // bit slot, 0 .. 14+len
    logic [7:0]            last_slot;
    logic [7:0]            code_pos;  // index into entry.bits

    assign last_slot = 8'(entry.len) + 8'(huff_pkg::hdr_w - 1);
    assign code_pos  = last_slot - slot;  // first move comes out first

    always_comb begin
        if (slot < 8'(huff_pkg::sym_w)) begin
            bit_data = entry.sym[huff_pkg::sym_w - 1 - int'(slot)];
        end else if (slot < 8'(huff_pkg::hdr_w)) begin
            bit_data = entry.len[huff_pkg::hdr_w - 1 - int'(slot)];
        end else begin
            bit_data = entry.bits[code_pos[huff_pkg::len_w-1:0]];
        end
    end

    assign bit_valid  = busy;
    assign sym_start  = busy && (slot == 8'd0);
    assign write_done = busy && (slot == last_slot);  // 15+len cycles after code_found

    always_ff @(posedge clk) begin
        if (code_found) begin
            entry <= code;  // only valid in the strobe cycle
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            slot <= '0;
        end else if (code_found) begin
            busy <= 1'b1;
            slot <= '0;
        end else if (busy) begin
            if (slot == last_slot) begin
                busy <= 1'b0;
            end
            slot <= slot + 8'd1;
        end
    end

endmodule

// ==== src/huff_codebook_top.sv ====
/* codebook generator: node memory -> walker -> serial writer
   load the tree before start; serial output must be taken every cycle */

`timescale 1ns/10ps

module huff_codebook_top #(
    parameter int node_count = 128
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       load_en,
    input  logic [huff_pkg::idx_w-1:0] load_index,
    input  huff_pkg::node_t            load_node,
    input  logic                       start,
    input  logic [huff_pkg::idx_w-1:0] root_index,
    output logic                       bit_valid,
    output logic                       bit_data,
    output logic                       sym_start,
    output logic                       done
);

    logic                       rd_req, rd_valid;
    logic [huff_pkg::idx_w-1:0] rd_index;
    huff_pkg::node_t            rd_node;
    logic                       code_found, write_done;
    huff_pkg::code_entry_t      code;

    htree_mem #(.node_count(node_count)) i_mem (
        .clk(clk), .rst(rst),
        .load_en(load_en), .load_index(load_index), .load_node(load_node),
        .rd_req(rd_req), .rd_index(rd_index), .rd_valid(rd_valid), .rd_node(rd_node)
    );

    cb_walker i_walker (
        .clk(clk), .rst(rst), .start(start), .root_index(root_index),
        .rd_valid(rd_valid), .rd_node(rd_node), .write_done(write_done),
        .rd_req(rd_req), .rd_index(rd_index),
        .code_found(code_found), .code(code), .done(done)
    );

    code_writer i_writer (
        .clk(clk), .rst(rst), .code_found(code_found), .code(code),
        .bit_valid(bit_valid), .bit_data(bit_data),
        .sym_start(sym_start), .write_done(write_done)
    );

endmodule

// ==== bench/huff_codebook_properties.sv ====
/* stream timing rules, bound into huff_codebook_top
   an entry is 15+len back-to-back bits, the first one flagged by sym_start */

`timescale 1ns/10ps

module huff_codebook_properties (
    input logic                       clk,
    input logic                       rst,
    input logic                       start,
    input logic                       code_found,
    input logic                       write_done,
    input logic [huff_pkg::len_w-1:0] code_len,
    input logic                       bit_valid,
    input logic                       sym_start,
    input logic                       done
);

    int         prop_errors = 0;  // failed assertions so far
    logic [7:0] left_bits;        // bits still owed for the entry in flight
    logic       seen_start;       // a start has been seen since reset

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            left_bits  <= '0;
            seen_start <= 1'b0;
        end else begin
            if (start) begin
                seen_start <= 1'b1;
            end
            if (code_found) begin
                left_bits <= 8'(code_len) + 8'd15;  // symbol + length + code
            end else if (bit_valid && (left_bits != 8'd0)) begin
                left_bits <= left_bits - 8'd1;
            end
        end
    end

    no_overlap: assert property (@(posedge clk) disable iff (rst) code_found |-> !bit_valid)
        else begin
            $error("code_found arrived while the writer was still busy");
            prop_errors++;
        end

    first_bit: assert property (@(posedge clk) disable iff (rst) code_found |=> sym_start)
        else begin
            $error("sym_start missing on the first bit after code_found");
            prop_errors++;
        end

    no_extra_bits: assert property (@(posedge clk) disable iff (rst)
        bit_valid |-> (left_bits != 8'd0))
        else begin
            $error("bit_valid high with no entry in flight");
            prop_errors++;
        end

    back_to_back: assert property (@(posedge clk) disable iff (rst)
        (bit_valid && (left_bits > 8'd1)) |=> (bit_valid && !sym_start))
        else begin
            $error("entry bits were not sent on consecutive cycles");
            prop_errors++;
        end

    last_bit: assert property (@(posedge clk) disable iff (rst)
        (bit_valid && (left_bits == 8'd1)) |-> write_done ##1 !bit_valid)
        else begin
            $error("write_done not on the last bit, or bit_valid stayed high after it");
            prop_errors++;
        end

    quiet_until_start: assert property (@(posedge clk) disable iff (rst)
        !seen_start |-> (!bit_valid && !sym_start && !done))
        else begin
            $error("outputs active before the first start");
            prop_errors++;
        end

endmodule

bind huff_codebook_top huff_codebook_properties i_props (
    .clk(clk), .rst(rst), .start(start), .code_found(code_found),
    .write_done(write_done), .code_len(code.len), .bit_valid(bit_valid),
    .sym_start(sym_start), .done(done)
);

// ==== bench/tb_huff_codebook.sv ====
/* loads fixed and random trees, runs each walk and checks the serial codebook
   against a depth-first reference walk of the same tree; trees sit below index 80 */

`timescale 1ns/10ps

module tb_huff_codebook;

    localparam int n_random    = 8;
    localparam int n_trees     = n_random + 3;  // + balanced, skewed, one-symbol
    localparam int cycle_limit = 2000;          // per tree

    logic                       clk, rst, load_en, start;
    logic                       bit_valid, bit_data, sym_start, done;
    logic [huff_pkg::idx_w-1:0] load_index, root_index;
    huff_pkg::node_t            load_node;

    huff_pkg::node_t       tn [128];           // testbench copy of the tree
    huff_pkg::code_entry_t exp_q[$], got_q[$];
    huff_pkg::code_entry_t cap = '0;           // entry being reassembled
    int                    nbits = 0;
    int                    errors = 0;
    logic [31:0]           lfsr = 32'hfaa0;

    huff_codebook_top #(.node_count(128)) i_huff_codebook_top (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1
    endfunction

    function automatic int rand_bits(int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r = (r << 1) | int'(lfsr[0]);
        end
        return r;
    endfunction

    task automatic report_fail(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        errors++;
    endtask

    // rebuild entries from the stream, sampled away from the driving edge
    always @(negedge clk) begin
        if (bit_valid) begin
            if (sym_start) begin
                nbits = 0;
                cap   = '0;
            end
            if (nbits < 8) begin
                cap.sym = {cap.sym[6:0], bit_data};
            end else if (nbits < 15) begin
                cap.len = {cap.len[5:0], bit_data};
            end else begin
                cap.bits = {cap.bits[125:0], bit_data};
            end
            nbits++;
            if ((nbits > 15) && (nbits == 15 + int'(cap.len))) begin
                got_q.push_back(cap);
            end
        end
    end

    task automatic set_child(input int s, input huff_pkg::child_t c);
        if (s[0]) begin
            tn[s >> 1].right = c;
        end else begin
            tn[s >> 1].left = c;
        end
    endtask

    // random full binary tree: keep splitting a random leaf slot
    task automatic build_random(input int base, input int nleaf);
        int          slots[$];
        int          pick, s, nn;
        logic [7:0]  sym;
        bit          used[256];
        used  = '{default: 1'b0};
        nn    = 1;
        slots = '{2 * base, 2 * base + 1};
        while (slots.size() < nleaf) begin
            pick = rand_bits(4) % slots.size();
            s    = slots[pick];
            slots.delete(pick);
            set_child(s, '{is_sum: 1'b1, value: 8'(base + nn)});
            slots.push_back(2 * (base + nn));
            slots.push_back(2 * (base + nn) + 1);
            nn++;
        end
        foreach (slots[i]) begin
            do sym = 8'(rand_bits(8)); while (used[sym]);  // distinct symbols
            used[sym] = 1'b1;
            set_child(slots[i], '{is_sum: 1'b0, value: sym});
        end
    endtask

    // depth first, left before right, explicit stack
    task automatic ref_walk(input int root);
        huff_pkg::child_t st_c[$];
        logic [126:0]     st_b[$];
        int               st_l[$];
        huff_pkg::child_t c;
        logic [126:0]     b;
        int               l;
        exp_q.delete();
        st_c.push_back('{is_sum: 1'b1, value: 8'(root)});
        st_b.push_back('0);
        st_l.push_back(0);
        while (st_c.size() > 0) begin
            c = st_c.pop_back();
            b = st_b.pop_back();
            l = st_l.pop_back();
            if (c != huff_pkg::null_child) begin
                if (!c.is_sum) begin
                    exp_q.push_back('{sym: c.value, len: 7'(l), bits: b});
                end else begin
                    st_c.push_back(tn[c.value[6:0]].right);
                    st_b.push_back({b[125:0], 1'b1});
                    st_l.push_back(l + 1);
                    st_c.push_back(tn[c.value[6:0]].left);  // popped first
                    st_b.push_back({b[125:0], 1'b0});
                    st_l.push_back(l + 1);
                end
            end
        end
    endtask

    task automatic run_tree(input int root, input int count, input int leaves);
        int cycles;
        for (int k = root; k < root + count; k++) begin
            @(posedge clk);
            load_en    <= 1'b1;
            load_index <= 7'(k);
            load_node  <= tn[k];
        end
        @(posedge clk);
        load_en    <= 1'b0;
        start      <= 1'b1;
        root_index <= 7'(root);
        got_q.delete();
        @(posedge clk);
        start <= 1'b0;
        ref_walk(root);
        cycles = 0;
        @(negedge clk);
        while (!done && (cycles < cycle_limit)) begin
            @(negedge clk);
            cycles++;
        end
        assert (done) else report_fail($sformatf("walk from root %0d never reached done", root));
        assert ((got_q.size() == leaves) && (exp_q.size() == leaves))
            else report_fail($sformatf("%0d entries, expected %0d", got_q.size(), leaves));
        foreach (exp_q[i]) begin
            if (i < got_q.size()) begin
                assert (got_q[i] == exp_q[i]) else report_fail($sformatf(
                    "entry %0d: sym %h len %0d code %h, expected sym %h len %0d code %h", i,
                    got_q[i].sym, got_q[i].len, got_q[i].bits,
                    exp_q[i].sym, exp_q[i].len, exp_q[i].bits));
            end
        end
        foreach (got_q[i]) begin
            foreach (got_q[j]) begin
                if ((i != j) && (got_q[i].len <= got_q[j].len)) begin
                    assert ((got_q[j].bits >> (got_q[j].len - got_q[i].len)) != got_q[i].bits)
                        else report_fail($sformatf("code %0d is a prefix of code %0d", i, j));
                end
            end
        end
    endtask

    initial begin
        int base, nleaf;
        rst        = 1'b1;
        load_en    = 1'b0;
        load_index = '0;
        load_node  = '0;
        start      = 1'b0;
        root_index = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        repeat (4) @(negedge clk);
        assert (!done && !bit_valid && !sym_start) else report_fail("outputs active before start");
        for (int k = 0; k < 7; k++) begin  // balanced, 8 symbols at depth 3
            if (k < 3) begin
                tn[k] = '{left: '{1'b1, 8'(2 * k + 1)}, right: '{1'b1, 8'(2 * k + 2)}};
            end else begin
                tn[k] = '{left: '{1'b0, 8'(16 + 2 * k)}, right: '{1'b0, 8'(17 + 2 * k)}};
            end
        end
        run_tree(0, 7, 8);
        for (int k = 0; k < 11; k++) begin  // left-skewed chain, deepest code 11 moves
            if (k < 10) begin
                tn[k].left = '{is_sum: 1'b1, value: 8'(k + 1)};
            end else begin
                tn[k].left = '{is_sum: 1'b0, value: 8'hc0};
            end
            tn[k].right = '{is_sum: 1'b0, value: 8'(8'ha0 + k)};
        end
        run_tree(0, 11, 12);
        tn[20] = '{left: huff_pkg::null_child, right: huff_pkg::null_child};
        run_tree(20, 1, 0);  // one-symbol tree emits nothing
        for (int t = 0; t < n_random; t++) begin
            base  = rand_bits(6);
            nleaf = 2 + rand_bits(4) % 11;
            build_random(base, nleaf);
            run_tree(base, nleaf - 1, nleaf);
        end
        $display("errors: %0d check failures, %0d property failures",
                 errors, i_huff_codebook_top.i_props.prop_errors);
        if ((errors == 0) && (i_huff_codebook_top.i_props.prop_errors == 0)) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (n_trees * cycle_limit) @(posedge clk);
        $display("timeout: run still busy after %0d cycles", n_trees * cycle_limit);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== huff_codebook.f ====
common/huff_pkg.sv
src/htree_mem.sv
codebook/cb_walker.sv
codebook/code_writer.sv
src/huff_codebook_top.sv
bench/huff_codebook_properties.sv
bench/tb_huff_codebook.sv

// ==== Makefile ====
# Verilator build and run of the codebook generator testbench

VERILATOR ?= verilator
TOP       ?= tb_huff_codebook
FILELIST  ?= huff_codebook.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -qx "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
